// File: verilog.f
design/tl_pkg.sv
design/uart_pkg.sv
design/sync_fifo.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_regs.sv
design/uart_periph.sv
verif/uart_periph_tb.sv

// File: Makefile
# Verilator build and run of the UART peripheral testbench

VERILATOR ?= verilator
TOP       ?= uart_periph_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
SIM_FLAGS ?= --binary --timing

PASS_MSG := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR SIM_FLAGS"

test:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/uart_periph_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_periph_tb;

    localparam uart_pkg::baud_div_t SLOW_DIV = 16'd64;
    // bytes sent over the line in all tests together
    localparam int TOTAL_BYTES   = 35;
    localparam int TIMEOUT_LIMIT = TOTAL_BYTES * 10 * SLOW_DIV * 3 + 2000;

    logic          clk;
    logic          rstn;
    tl_pkg::tl_a_t req;
    logic          req_valid;
    logic          req_ready;
    tl_pkg::tl_d_t rsp;
    logic          rsp_valid;
    logic          rsp_ready;
    logic          tx_line;
    logic          line_hold;
    wire           rx_line;

    // reference model state
    uart_pkg::uart_ctrl_t m_ctrl;
    uart_pkg::uart_byte_t rx_q[$];
    int                   rx_held;
    int                   tx_held;
    logic                 known;

    tl_pkg::tl_d_t    exp_q[$];
    tl_pkg::tl_data_t mask_q[$];
    tl_pkg::tl_d_t    exp_rsp;
    tl_pkg::tl_data_t exp_mask;

    logic [31:0]         rng;
    int                  errors;
    int                  checks;
    int                  cycles;
    int                  i;
    int                  wc;
    uart_pkg::baud_div_t fast_div;
    uart_pkg::uart_byte_t b;

    // serial loopback
    assign rx_line = line_hold ? 1'b1 : tx_line;

    uart_periph u_dut (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .rsp_o       (rsp),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rx_i        (rx_line),
        .tx_o        (tx_line)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic tl_pkg::tl_addr_t reg_addr(input logic [3:0] ofs);
        return uart_pkg::UART_BASE | {28'd0, ofs};
    endfunction

    function automatic tl_pkg::tl_data_t ctrl_word(input uart_pkg::baud_div_t div,
                                                   input logic rx_en, input logic tx_en);
        return {div, 14'd0, rx_en, tx_en};
    endfunction

    // expected response and model update for one accepted request
    function automatic tl_pkg::tl_d_t ref_response(input tl_pkg::tl_op_e op,
                                                   input tl_pkg::tl_addr_t addr,
                                                   input tl_pkg::tl_data_t data,
                                                   output tl_pkg::tl_data_t mask);
        tl_pkg::tl_d_t d;
        logic          hit;
        logic          is_get;
        logic          is_put;
        d.op   = tl_pkg::TL_ACK;
        d.size = tl_pkg::TL_SIZE_WORD;
        d.data = '0;
        mask   = '1;
        hit    = (addr & ~uart_pkg::UART_MASK) == uart_pkg::UART_BASE;
        is_get = (op == tl_pkg::TL_GET);
        is_put = (op == tl_pkg::TL_PUT_FULL) || (op == tl_pkg::TL_PUT_PART);
        if (hit) begin
            case (addr[3:0])
                uart_pkg::REG_CTRL: begin
                    if (is_get) begin
                        d.op   = tl_pkg::TL_ACK_DATA;
                        d.data = m_ctrl;
                    end else if (is_put) begin
                        m_ctrl = data;
                        if (m_ctrl.tx_en && tx_held != 0) begin
                            known = 1'b0;
                        end
                    end
                end
                uart_pkg::REG_STATUS: begin
                    if (is_get) begin
                        d.op   = tl_pkg::TL_ACK_DATA;
                        d.data = {28'd0, rx_held == 0, rx_held >= 16, tx_held == 0,
                                  tx_held >= 16};
                        // FIFO levels unknown while bytes are on the line
                        if (!known) begin
                            mask = '0;
                        end
                    end
                end
                uart_pkg::REG_RDATA: begin
                    if (is_get) begin
                        d.op = tl_pkg::TL_ACK_DATA;
                        if (rx_q.size() == 0) begin
                            errors++;
                            $display("receive read issued with no byte expected at %0t", $time);
                        end else begin
                            d.data = {24'd0, rx_q.pop_front()};
                        end
                        if (rx_held > 0) begin
                            rx_held--;
                        end
                    end
                end
                uart_pkg::REG_WDATA: begin
                    if (is_put) begin
                        if (m_ctrl.rx_en) begin
                            rx_q.push_back(data[7:0]);
                        end
                        if (m_ctrl.tx_en) begin
                            known = 1'b0;
                        end else begin
                            tx_held++;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
        return d;
    endfunction

    task automatic bus_access(input tl_pkg::tl_op_e op, input tl_pkg::tl_addr_t addr,
                              input tl_pkg::tl_data_t data, output int wait_cyc);
        tl_pkg::tl_data_t mask;
        int               stall;
        req.op    = op;
        req.size  = tl_pkg::TL_SIZE_WORD;
        req.addr  = addr;
        req.data  = data;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        // transfer happens at the coming edge
        exp_q.push_back(ref_response(op, addr, data, mask));
        mask_q.push_back(mask);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        wait_cyc  = 0;
        @(negedge clk);
        while (!rsp_valid) begin
            @(negedge clk);
            wait_cyc++;
        end
        stall = int'(xorshift() % 32'd4);
        repeat (stall) @(posedge clk);
        @(posedge clk);
        #1;
        rsp_ready = 1'b1;
        @(posedge clk);
        #1;
        rsp_ready = 1'b0;
        @(negedge clk);
        if (rsp_valid) begin
            errors++;
            $display("response still valid after its handshake at %0t", $time);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input tl_pkg::tl_addr_t addr, input tl_pkg::tl_data_t data);
        int             wait_cyc;
        tl_pkg::tl_op_e op;
        op = xorshift() % 32'd2 == 0 ? tl_pkg::TL_PUT_FULL : tl_pkg::TL_PUT_PART;
        bus_access(op, addr, data, wait_cyc);
        if (wait_cyc != 0) begin
            errors++;
            $display("FAIL %0t: write answered %0d cycles late", $time, wait_cyc);
        end
    endtask

    task automatic bus_read(input tl_pkg::tl_addr_t addr);
        int wait_cyc;
        bus_access(tl_pkg::TL_GET, addr, '0, wait_cyc);
        // only a receive read may wait for data
        if (addr[3:0] != uart_pkg::REG_RDATA && wait_cyc != 0) begin
            errors++;
            $display("FAIL %0t: read answered %0d cycles late", $time, wait_cyc);
        end
    endtask

    // line idle long enough that every queued byte has landed
    task automatic settle();
        int idle;
        idle = 0;
        while (idle < 11 * int'(m_ctrl.baud_div)) begin
            @(posedge clk);
            #1;
            idle = tx_line ? idle + 1 : 0;
        end
        if (m_ctrl.tx_en) begin
            tx_held = 0;
        end
        rx_held = rx_q.size();
        known   = 1'b1;
    endtask

    always @(negedge clk) begin
        if (rstn && rsp_valid && req_ready) begin
            errors++;
            $display("FAIL %0t: request ready while a response is pending", $time);
        end
        if (rstn && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("response at %0t with no request outstanding", $time);
            end else begin
                exp_rsp  = exp_q.pop_front();
                exp_mask = mask_q.pop_front();
                checks++;
                if (rsp.op != exp_rsp.op || rsp.size != exp_rsp.size ||
                    ((rsp.data ^ exp_rsp.data) & exp_mask) != '0) begin
                    errors++;
                    $display("FAIL %0t: op/size/data %0d/%0d/%08h, expected %0d/%0d/%08h",
                             $time, rsp.op, rsp.size, rsp.data, exp_rsp.op, exp_rsp.size,
                             exp_rsp.data & exp_mask);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        line_hold = 1'b1;
        rng       = 32'd39;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        m_ctrl    = '0;
        rx_held   = 0;
        tx_held   = 0;
        known     = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rstn      = 1'b1;
        line_hold = 1'b0;
        @(negedge clk);
        if (rsp_valid !== 1'b0 || req_ready !== 1'b1 || tx_line !== 1'b1) begin
            errors++;
            $display("FAIL %0t: wrong bus or line state after reset", $time);
        end
        @(posedge clk);
        #1;

        // reset values and control write readback
        bus_read(reg_addr(uart_pkg::REG_STATUS));
        bus_read(reg_addr(uart_pkg::REG_CTRL));
        fast_div = uart_pkg::baud_div_t'(4 + xorshift() % 32'd5);
        bus_write(reg_addr(uart_pkg::REG_CTRL), ctrl_word(fast_div, 1'b1, 1'b1));
        bus_read(reg_addr(uart_pkg::REG_CTRL));

        // loopback in order
        for (i = 0; i < 12; i++) begin
            b = uart_pkg::uart_byte_t'(xorshift());
            bus_write(reg_addr(uart_pkg::REG_WDATA), {24'd0, b});
        end
        for (i = 0; i < 12; i++) begin
            bus_read(reg_addr(uart_pkg::REG_RDATA));
        end

        // receive read blocks until the byte lands
        bus_write(reg_addr(uart_pkg::REG_CTRL), ctrl_word(SLOW_DIV, 1'b1, 1'b1));
        b = uart_pkg::uart_byte_t'(xorshift());
        bus_write(reg_addr(uart_pkg::REG_WDATA), {24'd0, b});
        bus_access(tl_pkg::TL_GET, reg_addr(uart_pkg::REG_RDATA), '0, wc);
        if (wc < 8 * SLOW_DIV) begin
            errors++;
            $display("FAIL %0t: receive read answered after %0d cycles", $time, wc);
        end

        // fill with tx off and park one byte behind a full FIFO
        bus_write(reg_addr(uart_pkg::REG_CTRL), ctrl_word(SLOW_DIV, 1'b1, 1'b0));
        settle();
        for (i = 0; i < 16; i++) begin
            b = uart_pkg::uart_byte_t'(xorshift());
            bus_write(reg_addr(uart_pkg::REG_WDATA), {24'd0, b});
        end
        bus_read(reg_addr(uart_pkg::REG_STATUS));
        bus_write(reg_addr(uart_pkg::REG_CTRL), ctrl_word(SLOW_DIV, 1'b1, 1'b1));
        for (i = 0; i < 2; i++) begin
            b = uart_pkg::uart_byte_t'(xorshift());
            bus_write(reg_addr(uart_pkg::REG_WDATA), {24'd0, b});
        end
        @(negedge clk);
        if (req_ready) begin
            errors++;
            $display("FAIL %0t: request ready while a transmit byte is parked", $time);
        end
        @(posedge clk);
        #1;
        for (i = 0; i < 18; i++) begin
            bus_read(reg_addr(uart_pkg::REG_RDATA));
        end

        // rx off drops what comes in
        bus_write(reg_addr(uart_pkg::REG_CTRL), ctrl_word(fast_div, 1'b0, 1'b1));
        for (i = 0; i < 4; i++) begin
            b = uart_pkg::uart_byte_t'(xorshift());
            bus_write(reg_addr(uart_pkg::REG_WDATA), {24'd0, b});
        end
        settle();
        bus_read(reg_addr(uart_pkg::REG_STATUS));

        // misses and wrong ops
        bus_write(32'h3000_0000, 32'hFFFF_FFFF);
        bus_write(uart_pkg::UART_BASE + 32'h10, 32'hFFFF_FFFF);
        bus_read(32'h3000_0004);
        bus_read(reg_addr(uart_pkg::REG_WDATA));
        bus_write(reg_addr(uart_pkg::REG_STATUS), 32'hFFFF_FFFF);
        bus_read(reg_addr(uart_pkg::REG_CTRL));

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d responses never arrived", exp_q.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/uart_periph.sv
`timescale 1ns/1ps
`default_nettype none

module uart_periph (
    input  wire           clk_i,
    input  wire           rstn_i,
    input  tl_pkg::tl_a_t req_i,
    input  wire           req_valid_i,
    output logic          req_ready_o,
    output tl_pkg::tl_d_t rsp_o,
    output logic          rsp_valid_o,
    input  wire           rsp_ready_i,
    input  wire           rx_i,
    output logic          tx_o
);

    uart_pkg::uart_ctrl_t   ctrl;
    uart_pkg::uart_status_t status;
    uart_pkg::baud_div_t    baud_div;
    logic                   tx_en;
    logic                   rx_en;

    uart_pkg::uart_byte_t rx_byte;
    logic                 rx_byte_valid;
    uart_pkg::uart_byte_t rx_fifo_data;
    logic                 rx_pop;
    logic                 rx_full;
    logic                 rx_empty;

    uart_pkg::uart_byte_t tx_wdata;
    logic                 tx_push;
    uart_pkg::uart_byte_t tx_fifo_data;
    logic                 tx_pop;
    logic                 tx_full;
    logic                 tx_empty;

    assign tx_en    = ctrl.tx_en;
    assign rx_en    = ctrl.rx_en;
    assign baud_div = ctrl.baud_div;

    assign status = '{
        rx_empty: rx_empty,
        rx_full:  rx_full,
        tx_empty: tx_empty,
        tx_full:  tx_full
    };

    uart_regs u_regs (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .rsp_o       (rsp_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .ctrl_o      (ctrl),
        .status_i    (status),
        .rx_data_i   (rx_fifo_data),
        .rx_pop_o    (rx_pop),
        .tx_data_o   (tx_wdata),
        .tx_push_o   (tx_push)
    );

    // received bytes are dropped while rx is off
    sync_fifo #(
        .WIDTH ($bits(uart_pkg::uart_byte_t)),
        .DEPTH (uart_pkg::FIFO_DEPTH)
    ) u_rx_fifo (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .wr_en_i   (rx_byte_valid && rx_en),
        .wr_data_i (rx_byte),
        .rd_en_i   (rx_pop),
        .rd_data_o (rx_fifo_data),
        .full_o    (rx_full),
        .empty_o   (rx_empty)
    );

    sync_fifo #(
        .WIDTH ($bits(uart_pkg::uart_byte_t)),
        .DEPTH (uart_pkg::FIFO_DEPTH)
    ) u_tx_fifo (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .wr_en_i   (tx_push),
        .wr_data_i (tx_wdata),
        .rd_en_i   (tx_pop),
        .rd_data_o (tx_fifo_data),
        .full_o    (tx_full),
        .empty_o   (tx_empty)
    );

    uart_rx u_rx (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .rx_i         (rx_i),
        .baud_div_i   (baud_div),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_byte_valid)
    );

    uart_tx u_tx (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .tx_en_i      (tx_en),
        .baud_div_i   (baud_div),
        .data_i       (tx_fifo_data),
        .data_avail_i (!tx_empty),
        .pop_o        (tx_pop),
        .tx_o         (tx_o)
    );

endmodule

`default_nettype wire

// File: design/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    input  tl_pkg::tl_a_t          req_i,
    input  wire                    req_valid_i,
    output logic                   req_ready_o,
    output tl_pkg::tl_d_t          rsp_o,
    output logic                   rsp_valid_o,
    input  wire                    rsp_ready_i,
    output uart_pkg::uart_ctrl_t   ctrl_o,
    input  uart_pkg::uart_status_t status_i,
    input  uart_pkg::uart_byte_t   rx_data_i,
    output logic                   rx_pop_o,
    output uart_pkg::uart_byte_t   tx_data_o,
    output logic                   tx_push_o
);

    uart_pkg::regs_state_e state_q;
    uart_pkg::regs_state_e state_d;
    uart_pkg::uart_ctrl_t  ctrl_q;
    uart_pkg::uart_ctrl_t  ctrl_d;
    tl_pkg::tl_d_t         rsp_q;
    tl_pkg::tl_d_t         rsp_d;
    logic                  rsp_valid_q;
    logic                  rsp_valid_d;
    uart_pkg::uart_byte_t  park_q;
    uart_pkg::uart_byte_t  park_d;

    logic       hit;
    logic [3:0] ofs;
    logic       is_get;
    logic       is_put;

    assign hit    = (req_i.addr & ~uart_pkg::UART_MASK) == uart_pkg::UART_BASE;
    assign ofs    = req_i.addr[3:0];
    assign is_get = (req_i.op == tl_pkg::TL_GET);
    assign is_put = (req_i.op == tl_pkg::TL_PUT_FULL) || (req_i.op == tl_pkg::TL_PUT_PART);

    // one request in flight at a time
    assign req_ready_o = (state_q == uart_pkg::ST_IDLE) && !rsp_valid_q;
    assign rsp_o       = rsp_q;
    assign rsp_valid_o = rsp_valid_q;
    assign ctrl_o      = ctrl_q;

    always_comb begin
        state_d     = state_q;
        ctrl_d      = ctrl_q;
        rsp_d       = rsp_q;
        rsp_valid_d = rsp_valid_q;
        park_d      = park_q;
        rx_pop_o    = 1'b0;
        tx_push_o   = 1'b0;
        tx_data_o   = park_q;

        if (rsp_valid_q && rsp_ready_i) begin
            rsp_valid_d = 1'b0;
        end

        case (state_q)
            uart_pkg::ST_IDLE: begin
                if (req_valid_i && req_ready_o) begin
                    // default answer covers misses and wrong ops
                    rsp_valid_d = 1'b1;
                    rsp_d.op    = tl_pkg::TL_ACK;
                    rsp_d.size  = tl_pkg::TL_SIZE_WORD;
                    rsp_d.data  = '0;
                    if (hit) begin
                        case (ofs)
                            uart_pkg::REG_CTRL: begin
                                if (is_get) begin
                                    rsp_d.op   = tl_pkg::TL_ACK_DATA;
                                    rsp_d.data = ctrl_q;
                                end else if (is_put) begin
                                    ctrl_d = req_i.data;
                                end
                            end
                            uart_pkg::REG_STATUS: begin
                                if (is_get) begin
                                    rsp_d.op   = tl_pkg::TL_ACK_DATA;
                                    rsp_d.data = {28'd0, status_i};
                                end
                            end
                            uart_pkg::REG_RDATA: begin
                                if (is_get && status_i.rx_empty) begin
                                    // hold the read until a byte lands
                                    rsp_valid_d = 1'b0;
                                    state_d     = uart_pkg::ST_WAIT_DATA;
                                end else if (is_get) begin
                                    rx_pop_o   = 1'b1;
                                    rsp_d.op   = tl_pkg::TL_ACK_DATA;
                                    rsp_d.data = {24'd0, rx_data_i};
                                end
                            end
                            uart_pkg::REG_WDATA: begin
                                if (is_put && status_i.tx_full) begin
                                    park_d  = req_i.data[7:0];
                                    state_d = uart_pkg::ST_WAIT_SPACE;
                                end else if (is_put) begin
                                    tx_push_o = 1'b1;
                                    tx_data_o = req_i.data[7:0];
                                end
                            end
                            default: begin
                            end
                        endcase
                    end
                end
            end
            uart_pkg::ST_WAIT_DATA: begin
                if (!status_i.rx_empty) begin
                    rx_pop_o    = 1'b1;
                    rsp_valid_d = 1'b1;
                    rsp_d.op    = tl_pkg::TL_ACK_DATA;
                    rsp_d.size  = tl_pkg::TL_SIZE_WORD;
                    rsp_d.data  = {24'd0, rx_data_i};
                    state_d     = uart_pkg::ST_IDLE;
                end
            end
            uart_pkg::ST_WAIT_SPACE: begin
                // write already acked, push once there is room
                if (!status_i.tx_full) begin
                    tx_push_o = 1'b1;
                    state_d   = uart_pkg::ST_IDLE;
                end
            end
            default: begin
                state_d = uart_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q     <= uart_pkg::ST_IDLE;
            ctrl_q      <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            ctrl_q      <= ctrl_d;
            rsp_valid_q <= rsp_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        rsp_q  <= rsp_d;
        park_q <= park_d;
    end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                  clk_i,
    input  wire                  rstn_i,
    input  wire                  tx_en_i,
    input  uart_pkg::baud_div_t  baud_div_i,
    input  uart_pkg::uart_byte_t data_i,
    input  wire                  data_avail_i,
    output logic                 pop_o,
    output logic                 tx_o
);

    logic                busy_q;
    uart_pkg::baud_div_t cnt_q;
    logic [3:0]          bit_cnt_q;
    logic [9:0]          shift_q;

    // enable only checked between frames
    assign pop_o = tx_en_i && !busy_q && data_avail_i;
    assign tx_o  = shift_q[0];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            bit_cnt_q <= '0;
            shift_q   <= '1;
        end else if (pop_o) begin
            // stop, data, start
            busy_q    <= 1'b1;
            cnt_q     <= baud_div_i - 1'b1;
            bit_cnt_q <= '0;
            shift_q   <= {1'b1, data_i, 1'b0};
        end else if (busy_q) begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end else if (bit_cnt_q == 4'd9) begin
                // stop bit done, back to idle high
                busy_q  <= 1'b0;
                shift_q <= '1;
            end else begin
                cnt_q     <= baud_div_i - 1'b1;
                bit_cnt_q <= bit_cnt_q + 1'b1;
                shift_q   <= {1'b1, shift_q[9:1]};
            end
        end
    end

endmodule

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                  clk_i,
    input  wire                  rstn_i,
    input  wire                  rx_i,
    input  uart_pkg::baud_div_t  baud_div_i,
    output uart_pkg::uart_byte_t byte_o,
    output logic                 byte_valid_o
);

    logic                 rx_s1_q;
    logic                 rx_s2_q;
    logic                 busy_q;
    uart_pkg::baud_div_t  cnt_q;
    logic [3:0]           bit_cnt_q;
    uart_pkg::uart_byte_t shift_q;
    logic                 tick;

    // sample point of the current bit
    assign tick   = busy_q && (cnt_q == '0);
    assign byte_o = shift_q;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_s1_q <= 1'b1;
            rx_s2_q <= 1'b1;
        end else begin
            rx_s1_q <= rx_i;
            rx_s2_q <= rx_s1_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q       <= 1'b0;
            cnt_q        <= '0;
            bit_cnt_q    <= '0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;
            if (!busy_q) begin
                if (!rx_s2_q) begin
                    // first sample lands half a bit in
                    busy_q    <= 1'b1;
                    cnt_q     <= baud_div_i >> 1;
                    bit_cnt_q <= '0;
                end
            end else if (!tick) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                cnt_q <= baud_div_i - 1'b1;
                if (bit_cnt_q == 4'd0) begin
                    // glitch, not a real start bit
                    if (rx_s2_q) begin
                        busy_q <= 1'b0;
                    end else begin
                        bit_cnt_q <= 4'd1;
                    end
                end else if (bit_cnt_q == 4'd9) begin
                    // bad stop bit drops the byte
                    busy_q       <= 1'b0;
                    byte_valid_o <= rx_s2_q;
                end else begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
            end
        end
    end

    // lsb first
    always_ff @(posedge clk_i) begin
        if (tick && (bit_cnt_q != 4'd0) && (bit_cnt_q != 4'd9)) begin
            shift_q <= {rx_s2_q, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: design/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  wire              clk_i,
    input  wire              rstn_i,
    input  wire              wr_en_i,
    input  wire  [WIDTH-1:0] wr_data_i,
    input  wire              rd_en_i,
    output logic [WIDTH-1:0] rd_data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_wr;
    logic             do_rd;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o    = (count_q == CNT_W'(DEPTH));
    assign empty_o   = (count_q == '0);
    assign do_wr     = wr_en_i && !full_o;
    assign do_rd     = rd_en_i && !empty_o;
    assign rd_data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_rd) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/uart_pkg.sv
`default_nettype none

package uart_pkg;

    localparam logic [31:0] UART_BASE = 32'h2000_0000;
    localparam logic [31:0] UART_MASK = 32'h0000_000F;

    // word offsets inside the block
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_RDATA  = 4'h8;
    localparam logic [3:0] REG_WDATA  = 4'hC;

    localparam int FIFO_DEPTH = 16;

    typedef logic [7:0]  uart_byte_t;
    typedef logic [15:0] baud_div_t;

    typedef struct packed {
        baud_div_t   baud_div;
        logic [13:0] reserved;
        logic        rx_en;
        logic        tx_en;
    } uart_ctrl_t;

    typedef struct packed {
        logic rx_empty;
        logic rx_full;
        logic tx_empty;
        logic tx_full;
    } uart_status_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_DATA,
        ST_WAIT_SPACE
    } regs_state_e;

endpackage

`default_nettype wire

// File: design/tl_pkg.sv
`default_nettype none

package tl_pkg;

    localparam int TL_ADDR_W = 32;
    localparam int TL_DATA_W = 32;
    localparam int TL_SIZE_W = 3;

    typedef logic [TL_ADDR_W-1:0] tl_addr_t;
    typedef logic [TL_DATA_W-1:0] tl_data_t;
    typedef logic [TL_SIZE_W-1:0] tl_size_t;

    // log2 of the byte count, 2 for a full word
    localparam tl_size_t TL_SIZE_WORD = 3'd2;

    // A and D opcodes share one encoding space
    typedef enum logic [2:0] {
        TL_PUT_FULL = 3'd0,
        TL_PUT_PART = 3'd1,
        TL_ACK      = 3'd2,
        TL_ACK_DATA = 3'd3,
        TL_GET      = 3'd4
    } tl_op_e;

    // request channel
    typedef struct packed {
        tl_op_e   op;
        tl_size_t size;
        tl_addr_t addr;
        tl_data_t data;
    } tl_a_t;

    // response channel
    typedef struct packed {
        tl_op_e   op;
        tl_size_t size;
        tl_data_t data;
    } tl_d_t;

endpackage

`default_nettype wire
